// File: include/uart_cfg_cfg.svh
// Build-time sizes and addresses of the UART peripheral, included by every file that needs them
`ifndef UART_CFG_CFG_SVH
`define UART_CFG_CFG_SVH

// Peripheral bus, word addressed
`define UART_ADDR_WD 14
`define UART_BUS_WD 16

// Byte base address, aligned to the decoder width
`define UART_BASE_ADDR 15'h0080

// Byte-address bits seen by the register decoder
`define UART_DEC_WD 3

// Character and divisor widths
`define UART_DATA_WD 8
`define UART_BAUD_WD 16

// Writable CTRL bits, enables and line enable
`define UART_CTRL_MASK 8'hF1

`endif

// File: logic/uart_line_pkg.sv
// Serial line and frame types shared by the register bank and the two line engines
`include "uart_cfg_cfg.svh"

package uart_line_pkg;

  // One character on the line
  typedef logic [`UART_DATA_WD-1:0] data_t;

  // Baud divisor, one bit lasts divisor+1 cycles
  typedef logic [`UART_BAUD_WD-1:0] baud_t;

  // Frame bit index, zero means idle
  typedef logic [3:0] bit_idx_t;

  // Index after start, eight data and stop bits
  localparam bit_idx_t TX_LAST_BIT = 4'd11;

  // Receiver stops after the ninth sample, stop bit not sampled
  localparam bit_idx_t RX_LAST_BIT = 4'd10;

endpackage

// File: logic/uart_reg_pkg.sv
// Programmer's view of the UART: register offsets and the CTRL and STATUS bit layouts
`include "uart_cfg_cfg.svh"

package uart_reg_pkg;

  // Byte offsets inside the block
  // Bit 0 picks the high lane, upper bits give the word
  typedef enum logic [`UART_DEC_WD-1:0] {
    CTRL    = 3'd0,
    STATUS  = 3'd1,
    BAUD_LO = 3'd2,
    BAUD_HI = 3'd3,
    DATA_TX = 3'd4,
    DATA_RX = 3'd5
  } reg_ofs_e;

  // CTRL layout, reserved bits held at zero by the write mask
  typedef struct packed {
    logic       ien_tx_empty;
    logic       ien_tx;
    logic       ien_rx_ovflw;
    logic       ien_rx;
    logic [2:0] rsvd;
    logic       en;
  } ctrl_t;

  // STATUS layout, upper nibble is write-one-to-clear
  typedef struct packed {
    logic tx_empty_pnd;
    logic tx_pnd;
    logic rx_ovflw_pnd;
    logic rx_pnd;
    logic tx_full;
    logic tx_busy;
    logic rsvd;
    logic rx_busy;
  } status_t;

endpackage

// File: logic/uart_core_if.sv
// Bundle between the UART register bank and its transmit and receive engines
`timescale 1ns/10ps

interface uart_core_if;
  import uart_line_pkg::*;

  // Configuration from CTRL and BAUD
  logic  en;
  baud_t baud;

  // Transmit handshake, valid held until ready
  logic  tx_valid;
  data_t tx_data;
  logic  tx_ready;
  logic  tx_done;

  // Receive side, valid is a single pulse
  logic  rx_valid;
  data_t rx_data;
  logic  rx_busy;

  modport regs (output en, baud, tx_valid, tx_data,
                input tx_ready, tx_done, rx_valid, rx_data, rx_busy);
  modport tx (input en, baud, tx_valid, tx_data, output tx_ready, tx_done);
  modport rx (input en, baud, output rx_valid, rx_data, rx_busy);

endinterface

// File: logic/uart_regs.sv
// UART register bank: bus decode, CTRL/BAUD/DATA registers, sticky flags, read mux and interrupts
`timescale 1ns/10ps
`include "uart_cfg_cfg.svh"

module uart_regs (
  input  logic                       mclk,
  input  logic                       puc_rst,
  input  logic [`UART_ADDR_WD-1:0]   per_addr,
  input  logic [`UART_BUS_WD-1:0]    per_din,
  input  logic                       per_en,
  input  logic [1:0]                 per_we,
  output logic [`UART_BUS_WD-1:0]    per_dout,
  output logic                       irq_uart_rx,
  output logic                       irq_uart_tx,
  uart_core_if.regs                  core
);
  import uart_reg_pkg::*;
  import uart_line_pkg::*;

  localparam int DEC_SZ = 1 << `UART_DEC_WD;
  localparam logic [`UART_ADDR_WD:0] BASE = `UART_BASE_ADDR;

  logic              reg_sel;
  logic [DEC_SZ-1:0] reg_dec;
  logic [DEC_SZ-1:0] reg_wr;
  logic [DEC_SZ-1:0] reg_rd;
  ctrl_t             ctrl;
  status_t           status;
  logic [7:0]        baud_lo;
  logic [7:0]        baud_hi;
  data_t             data_tx;
  data_t             data_rx;
  logic              tx_pend;
  // Sticky flags in STATUS order: tx_empty, tx, rx_ovflw, rx
  logic [3:0]        pnd;
  logic [3:0]        pnd_set;
  logic [3:0]        pnd_clr;
  // STATUS byte as seen on its write lane
  logic [7:0]        status_din;

  // Byte of the write bus seen by one register
  function automatic logic [7:0] lane_in(input logic [`UART_BUS_WD-1:0] din,
                                         input reg_ofs_e ofs);
    return ofs[0] ? din[15:8] : din[7:0];
  endfunction

  // Register placed on its lane, zero when not read
  function automatic logic [`UART_BUS_WD-1:0] lane_out(input logic [7:0] val,
                                                       input logic sel,
                                                       input reg_ofs_e ofs);
    logic [7:0] gated;
    gated = val & {8{sel}};
    return ofs[0] ? {gated, 8'h00} : {8'h00, gated};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Word address compared against byte base shifted right by one
  assign reg_sel = per_en &
                   (per_addr[`UART_ADDR_WD-1:`UART_DEC_WD-1] == BASE[`UART_ADDR_WD:`UART_DEC_WD]);

  // One-hot select per offset, lane write strobes
  always_comb begin
    for (int i = 0; i < DEC_SZ; i++) begin
      reg_dec[i] = reg_sel & (per_addr[`UART_DEC_WD-2:0] == 2'(i >> 1));
      reg_wr[i]  = reg_dec[i] & per_we[i & 1];
      reg_rd[i]  = reg_dec[i] & ~|per_we;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ctrl    <= '0;
      baud_lo <= '0;
      baud_hi <= '0;
      data_tx <= '0;
    end else begin
      // Reserved CTRL bits never stick
      if (reg_wr[CTRL]) ctrl <= ctrl_t'(lane_in(per_din, CTRL) & `UART_CTRL_MASK);
      if (reg_wr[BAUD_LO]) baud_lo <= lane_in(per_din, BAUD_LO);
      if (reg_wr[BAUD_HI]) baud_hi <= lane_in(per_din, BAUD_HI);
      if (reg_wr[DATA_TX]) data_tx <= lane_in(per_din, DATA_TX);
    end
  end

  // Received byte latched on every completion, overflow reported separately
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      data_rx <= '0;
    end else if (core.rx_valid) begin
      data_rx <= core.rx_data;
    end
  end

  // Transmit pending, a new write wins over the handshake
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_pend <= 1'b0;
    end else if (reg_wr[DATA_TX]) begin
      tx_pend <= 1'b1;
    end else if (core.tx_ready) begin
      tx_pend <= 1'b0;
    end
  end

  // Sticky flags, hardware set beats write-one clear
  assign pnd_set = {core.tx_done & ~tx_pend, core.tx_done,
                    core.rx_valid & pnd[0], core.rx_valid};
  assign status_din = lane_in(per_din, STATUS);
  assign pnd_clr    = {4{reg_wr[STATUS]}} & status_din[7:4];

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      pnd <= '0;
    end else begin
      pnd <= (pnd & ~pnd_clr) | pnd_set;
    end
  end

  always_comb begin
    status = '0;
    {status.tx_empty_pnd, status.tx_pnd, status.rx_ovflw_pnd, status.rx_pnd} = pnd;
    status.tx_busy = tx_pend | ~core.tx_ready;
    status.tx_full = tx_pend & ~core.tx_ready;
    status.rx_busy = core.rx_busy;
  end

  // Core side
  assign core.en       = ctrl.en;
  assign core.baud     = {baud_hi, baud_lo};
  assign core.tx_valid = tx_pend;
  assign core.tx_data  = data_tx;

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and interrupts
  ////////////////////////////////////////////////////////////////////////////

  assign per_dout = lane_out(ctrl, reg_rd[CTRL], CTRL) |
                    lane_out(status, reg_rd[STATUS], STATUS) |
                    lane_out(baud_lo, reg_rd[BAUD_LO], BAUD_LO) |
                    lane_out(baud_hi, reg_rd[BAUD_HI], BAUD_HI) |
                    lane_out(data_tx, reg_rd[DATA_TX], DATA_TX) |
                    lane_out(data_rx, reg_rd[DATA_RX], DATA_RX);

  assign irq_uart_rx = (status.rx_pnd & ctrl.ien_rx) |
                       (status.rx_ovflw_pnd & ctrl.ien_rx_ovflw);
  assign irq_uart_tx = (status.tx_pnd & ctrl.ien_tx) |
                       (status.tx_empty_pnd & ctrl.ien_tx_empty);

  // At most one register per lane on a read
  a_lane_onehot: assert property (@(posedge mclk) disable iff (puc_rst)
    $onehot0(reg_rd & {DEC_SZ/2{2'b01}}) && $onehot0(reg_rd & {DEC_SZ/2{2'b10}}));

  // Pending byte is not dropped before the engine takes it
  a_tx_hold: assert property (@(posedge mclk) disable iff (puc_rst)
    core.tx_valid && !core.tx_ready |=> core.tx_valid);

endmodule

// File: logic/uart_tx.sv
// UART transmit engine: sends one 8N1 frame LSB first per handshake with the register bank
`timescale 1ns/10ps

module uart_tx (
  input  logic    mclk,
  input  logic    puc_rst,
  uart_core_if.tx core,
  output logic    uart_txd
);
  import uart_line_pkg::*;

  bit_idx_t              bit_idx;
  baud_t                 baud_cnt;
  // Start bit at bit 0, ones shifted in behind the data
  logic [$bits(data_t):0] shift;
  logic                  start;
  logic                  bit_inc;

  // Idle when no frame in flight
  assign core.tx_ready = (bit_idx == '0);
  assign start         = core.tx_valid & core.tx_ready;

  // Bit boundary once the divisor has run out
  assign bit_inc      = (bit_idx != '0) & (baud_cnt == '0);
  // Only one cycle at the last index
  assign core.tx_done = (bit_idx == TX_LAST_BIT);

  // Bit index, 1 is start bit, 10 stop bit
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bit_idx <= '0;
    end else if (!core.en) begin
      bit_idx <= '0;
    end else if (start) begin
      bit_idx <= bit_idx_t'(1);
    end else if (core.tx_done) begin
      bit_idx <= '0;
    end else if (bit_inc) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  // Baud down-counter, reloaded at each boundary
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      baud_cnt <= '0;
    end else if (!core.en) begin
      baud_cnt <= '0;
    end else if (start | bit_inc) begin
      baud_cnt <= core.baud;
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // Line register, all ones is an idle line
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      shift <= '1;
    end else if (!core.en) begin
      shift <= '1;
    end else if (start) begin
      shift <= {core.tx_data, 1'b0};
    end else if (bit_inc) begin
      shift <= {1'b1, shift[$bits(data_t):1]};
    end
  end

  assign uart_txd = shift[0];

  // Disabled engine idles the line by the next cycle
  a_txd_idle: assert property (@(posedge mclk) disable iff (puc_rst)
    !core.en |=> uart_txd);

endmodule

// File: logic/uart_rx.sv
// UART receive engine: filters the pin, finds the start edge and samples 8N1 frames mid-bit
`timescale 1ns/10ps

module uart_rx (
  input  logic    mclk,
  input  logic    puc_rst,
  uart_core_if.rx core,
  input  logic    uart_rxd
);
  import uart_line_pkg::*;

  logic [1:0] rxd_sync;
  logic [1:0] rxd_hist;
  logic       rxd_maj;
  logic       maj_nxt;
  logic       rxd_fe;
  bit_idx_t   bit_idx;
  baud_t      baud_cnt;
  data_t      rx_shift;
  logic       start;
  logic       bit_inc;

  ////////////////////////////////////////////////////////////////////////////
  // Line conditioning
  ////////////////////////////////////////////////////////////////////////////

  // Two-flop synchronizer, idle high out of reset
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_sync <= 2'b11;
      rxd_hist <= 2'b11;
      rxd_maj  <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
      rxd_hist <= {rxd_hist[0], rxd_sync[1]};
      rxd_maj  <= maj_nxt;
    end
  end

  // Two of three samples, rejects single-cycle glitches
  assign maj_nxt = (rxd_sync[1] & rxd_hist[0]) | (rxd_sync[1] & rxd_hist[1]) |
                   (rxd_hist[0] & rxd_hist[1]);
  assign rxd_fe  = rxd_maj & ~maj_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Frame timing
  ////////////////////////////////////////////////////////////////////////////

  assign start         = (bit_idx == '0) & rxd_fe;
  assign bit_inc       = (bit_idx != '0) & (baud_cnt == '0);
  assign core.rx_valid = (bit_idx == RX_LAST_BIT);
  assign core.rx_busy  = (bit_idx != '0);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      bit_idx <= '0;
    end else if (!core.en) begin
      bit_idx <= '0;
    end else if (start) begin
      bit_idx <= bit_idx_t'(1);
    end else if (core.rx_valid) begin
      bit_idx <= '0;
    end else if (bit_inc) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  // Half a bit to the first sample, full bits after
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      baud_cnt <= '0;
    end else if (!core.en) begin
      baud_cnt <= '0;
    end else if (start) begin
      baud_cnt <= core.baud >> 1;
    end else if (bit_inc) begin
      baud_cnt <= core.baud;
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // LSB first, start bit falls out the bottom after eight more samples
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_shift <= '0;
    end else if (bit_inc) begin
      rx_shift <= {rxd_maj, rx_shift[$bits(data_t)-1:1]};
    end
  end

  assign core.rx_data = rx_shift;

  // Completion is a single pulse per frame
  a_rx_pulse: assert property (@(posedge mclk) disable iff (puc_rst)
    core.rx_valid |=> !core.rx_valid);

endmodule

// File: logic/uart_periph.sv
// UART peripheral top level: 16-bit peripheral bus and serial pins around the register bank and engines
`timescale 1ns/10ps
`include "uart_cfg_cfg.svh"

module uart_periph (
  input  logic                     mclk,
  input  logic                     puc_rst,
  // Peripheral bus
  input  logic [`UART_ADDR_WD-1:0] per_addr,
  input  logic [`UART_BUS_WD-1:0]  per_din,
  input  logic                     per_en,
  input  logic [1:0]               per_we,
  output logic [`UART_BUS_WD-1:0]  per_dout,
  // Serial pins
  input  logic                     uart_rxd,
  output logic                     uart_txd,
  // Interrupts
  output logic                     irq_uart_rx,
  output logic                     irq_uart_tx
);

  // Register bank to engine bundle
  uart_core_if core ();

  uart_regs i_regs (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx),
    .core        (core.regs)
  );

  uart_tx i_tx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .core     (core.tx),
    .uart_txd (uart_txd)
  );

  uart_rx i_rx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .core     (core.rx),
    .uart_rxd (uart_rxd)
  );

endmodule

// File: dv/uart_periph_tb.sv
// Self-checking UART testbench: runs the bus and serial operations listed in the stimulus file
`timescale 1ns/10ps
`include "uart_cfg_cfg.svh"

module uart_periph_tb;

  logic                     mclk;
  logic                     puc_rst;
  logic [`UART_ADDR_WD-1:0] per_addr;
  logic [`UART_BUS_WD-1:0]  per_din;
  logic                     per_en;
  logic [1:0]               per_we;
  logic [`UART_BUS_WD-1:0]  per_dout;
  logic                     uart_rxd;
  logic                     uart_txd;
  logic                     irq_uart_rx;
  logic                     irq_uart_tx;
  // Loopback unless a frame is driven directly
  logic                     loop_break;
  logic                     rxd_drv;
  int                       errors;
  int                       checks;
  int                       baud;
  int                       wd_cycles;
  logic                     wd_armed;
  time                      last_fall;
  // Parsed operations
  logic [7:0]               op_q[$];
  int                       a_q[$];
  int                       b_q[$];
  int                       c_q[$];

  uart_periph i_dut (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .uart_rxd    (uart_rxd),
    .uart_txd    (uart_txd),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  assign uart_rxd = loop_break ? rxd_drv : uart_txd;

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;
  end

  // Start edge of the latest frame on the line
  always @(negedge uart_txd) last_fall = $time;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // BAUD word shadowed so that bit timing follows the divisor
  task automatic bus_write(input int addr, input int we, input int data);
    per_addr = addr[`UART_ADDR_WD-1:0];
    per_din  = data[15:0];
    per_we   = we[1:0];
    per_en   = 1'b1;
    if (addr == 'h41 && we[0]) baud[7:0] = data[7:0];
    if (addr == 'h41 && we[1]) baud[15:8] = data[15:8];
    @(negedge mclk);
    per_en = 1'b0;
    per_we = 2'b00;
  endtask

  // Read data sampled mid low phase
  task automatic bus_read(input int addr, input int exp, input logic en);
    per_addr = addr[`UART_ADDR_WD-1:0];
    per_we   = 2'b00;
    per_en   = en;
    #1;
    check_val("per_dout", 32'(per_dout), exp);
    @(negedge mclk);
    per_en = 1'b0;
  endtask

  // Sample each bit of a frame on uart_txd at its middle
  task automatic frame_check(input int data);
    time fall;
    time target;
    int  bit_ns;
    logic exp;
    bit_ns = (baud + 1) * 4;
    if (uart_txd) begin
      @(negedge uart_txd);
      fall = $time;
    end else begin
      fall = last_fall;
    end
    for (int k = 0; k < 10; k++) begin
      target = fall + k * bit_ns + ((baud + 1) / 2) * 4 + 1;
      #(target - $time);
      exp = (k == 0) ? 1'b0 : (k == 9) ? 1'b1 : data[k-1];
      check_val("uart_txd", 32'(uart_txd), 32'(exp));
    end
    @(negedge mclk);
  endtask

  // Start, data LSB first, stop on uart_rxd with the loop open
  task automatic frame_drive(input int data);
    logic [9:0] bits;
    bits = {1'b1, data[7:0], 1'b0};
    loop_break = 1'b1;
    for (int k = 0; k < 10; k++) begin
      rxd_drv = bits[k];
      repeat (baud + 1) @(negedge mclk);
    end
    loop_break = 1'b0;
  endtask

  // Limit of two frames at the current divisor
  task automatic irq_wait(input int sel);
    int n;
    int limit;
    n = 0;
    limit = 24 * (baud + 1);
    while (((sel == 0) ? irq_uart_rx : irq_uart_tx) !== 1'b1 && n < limit) begin
      @(negedge mclk);
      n++;
    end
    checks++;
    if (n >= limit) begin
      errors++;
      $display("Interrupt %s did not rise within %0d cycles at %0t",
               (sel == 0) ? "irq_uart_rx" : "irq_uart_tx", limit, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_stimulus();
    int         fd;
    int         n_ser;
    int         dly;
    int         bmax;
    int         a;
    int         b;
    int         c;
    logic [7:0] op;
    string      line;
    n_ser = 0;
    dly = 0;
    bmax = 0;
    fd = $fopen("dv/uart_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        a = 0;
        b = 0;
        c = 0;
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") continue;
        void'($sscanf(line, "%c %h %h %h", op, a, b, c));
        op_q.push_back(op);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        if (op == "T" || op == "S" || op == "I") n_ser++;
        if (op == "D") dly += a;
        if (op == "W" && a == 'h41 && c > bmax) bmax = c;
      end
      $fclose(fd);
    end
    // Serial frames dominate, bus operations get a few cycles each
    wd_cycles = 16 + n_ser * 12 * (bmax + 1) + dly + 20 * op_q.size() + 500;
  endtask

  task automatic run_op(input int i);
    case (op_q[i])
      "W": bus_write(a_q[i], b_q[i], c_q[i]);
      "R": bus_read(a_q[i], b_q[i], 1'b1);
      "N": bus_read(a_q[i], 0, 1'b0);
      "T": frame_check(a_q[i]);
      "S": frame_drive(a_q[i]);
      "I": irq_wait(a_q[i]);
      "D": repeat (a_q[i]) @(negedge mclk);
      "L": begin
        #1;
        check_val("uart_txd", 32'(uart_txd), a_q[i]);
        @(negedge mclk);
      end
      "Q": begin
        #1;
        check_val("irq_uart_rx", 32'(irq_uart_rx), a_q[i]);
        check_val("irq_uart_tx", 32'(irq_uart_tx), b_q[i]);
        @(negedge mclk);
      end
      default: begin
        errors++;
        $display("Unknown operation in stimulus line %0d", i);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    per_addr   = '0;
    per_din    = '0;
    per_en     = 1'b0;
    per_we     = 2'b00;
    loop_break = 1'b0;
    rxd_drv    = 1'b1;
    puc_rst    = 1'b1;
    errors     = 0;
    checks     = 0;
    baud       = 0;
    wd_armed   = 1'b0;
    last_fall  = 0;
    load_stimulus();
    wd_armed = 1'b1;
    repeat (16) @(posedge mclk);
    @(negedge mclk);
    puc_rst = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(i);
    end
    repeat (4) @(negedge mclk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_armed);
    repeat (wd_cycles) @(posedge mclk);
    $display("Watchdog expired after %0d cycles", wd_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: uart_periph.f
+incdir+include
logic/uart_line_pkg.sv
logic/uart_reg_pkg.sv
logic/uart_core_if.sv
logic/uart_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_periph.sv
dv/uart_periph_tb.sv

// File: Makefile
# Verilator build and run of the UART peripheral testbench

VERILATOR ?= verilator
TOP       ?= uart_periph_tb
FLIST     ?= uart_periph.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) include/uart_cfg_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/uart_stimulus.txt
# W addr lanes data | R addr expect | N addr (per_en low) | T byte on txd | S byte on rxd
# I 0=rx 1=tx irq wait | Q irq_rx irq_tx | L txd level | D cycles ; all values hex
R 40 0000
R 41 0000
R 42 0000
R 43 0000
W 40 1 00ff
R 40 00f1
W 41 3 0507
R 41 0507
W 41 2 0000
R 41 0007
N 40
R 50 0000
W 40 1 0001
W 42 1 0041
T 41
D 10
L 1
R 40 d001
R 42 4141
Q 0 0
W 40 1 00f1
Q 1 1
W 40 2 f000
Q 0 0
R 40 00f1
S 5a
S a5
I 0
R 40 30f1
R 42 a541
W 40 2 f000
Q 0 0
W 42 1 0011
W 42 1 0022
R 40 0cf1
T 11
R 42 1122
I 1
R 40 54f1
T 22
D 10
R 40 f0f1
R 42 2222
W 40 3 f0f1
W 42 1 0055
D 20
W 40 1 0000
D 2
L 1
D 100
R 40 0000
R 42 2255
